// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_uart_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: project.f
verilog/uart_pkg.sv
verilog/uart_bit_timer.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_core.sv
testbench/tb_uart_core.sv

// File: testbench/tb_uart_core.sv
`timescale 1ns/10ps

module tb_uart_core
    import uart_pkg::*;
();

    // Clock and run length.
    localparam int HALF_PERIOD      = 50;
    localparam int RESET_CYCLES     = 5;
    localparam int NUM_RANDOM       = 16;
    // Longest frame is 11 bits at 20 cycles per bit.
    localparam int MAX_FRAME_CYCLES = 11 * 20;
    // Random frames plus strobe, error, glitch and recovery frames.
    localparam int NUM_FRAMES       = NUM_RANDOM + 4;
    localparam int WATCHDOG_CYCLES  = 2 * NUM_FRAMES * MAX_FRAME_CYCLES + RESET_CYCLES;

    logic           clk = 1'b0;
    logic           resetn;
    uart_cfg_t      cfg;
    logic           tx_start;
    logic [7:0]     tx_data;
    logic           tx_busy;
    logic           uart_txd;
    logic           uart_rxd;
    logic           rx_valid;
    uart_rx_frame_t rx_frame;

    // Receive line source. Loopback or bit-banged by the testbench.
    logic loopback;
    logic bang_rxd;

    logic [31:0] rng;

    // Reference model. Frames still expected at the receiver, oldest first.
    uart_rx_frame_t exp_q[$];
    int             rx_count = 0;

    // tx_busy length tracking.
    int busy_len      = 0;
    int busy_expected = 0;

    assign uart_rxd = loopback ? uart_txd : bang_rxd;

    uart_core #(
        .MAX_DATA_BITS (8)
    ) i_dut (
        .clk      (clk),
        .resetn   (resetn),
        .cfg      (cfg),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .uart_txd (uart_txd),
        .uart_rxd (uart_rxd),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame)
    );

    initial begin
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // --------------------
    // Helpers.
    // --------------------

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                                      $time, msg, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Only the low data bits travel on the line.
    function automatic logic [7:0] masked(input logic [7:0] value, input int bits);
        logic [7:0] mask;
        mask = 8'hff >> (8 - bits);
        return value & mask;
    endfunction

    task automatic apply_config(input int cpb, input int db, input int sb);
        cfg.cycles_per_bit = 16'(cpb);
        cfg.data_bits      = 4'(db);
        cfg.stop_bits      = 2'(sb);
    endtask

    task automatic wait_for_frames(input int target);
        while (rx_count < target) @(negedge clk);
    endtask

    // Sends one byte, checks the line at each mid bit, then waits for loopback.
    task automatic send_and_check(input logic [7:0] value, input bit extra_strobe);
        uart_rx_frame_t frame;
        int             cpb;
        int             db;
        int             sb;
        int             target;
        cpb = int'(cfg.cycles_per_bit);
        db  = int'(cfg.data_bits);
        sb  = int'(cfg.stop_bits);
        frame.data        = masked(value, db);
        frame.frame_error = 1'b0;
        exp_q.push_back(frame);
        target = rx_count + 1;
        @(negedge clk);
        tx_start = 1'b1;
        tx_data  = value;
        @(negedge clk);
        tx_start = 1'b0;
        // First low cycle marks the start of the frame.
        while (uart_txd) @(negedge clk);
        repeat (cpb / 2) @(negedge clk);
        check(32'(uart_txd), 32'd0, "start bit");
        if (extra_strobe) begin
            // Transmitter is busy. This byte has to be dropped.
            tx_start = 1'b1;
            tx_data  = ~value;
            @(negedge clk);
            tx_start = 1'b0;
            repeat (cpb - 1) @(negedge clk);
        end else begin
            repeat (cpb) @(negedge clk);
        end
        for (int i = 0; i < db; i++) begin
            check(32'(uart_txd), 32'(value[i]), $sformatf("data bit %0d", i));
            repeat (cpb) @(negedge clk);
        end
        for (int i = 0; i < sb; i++) begin
            check(32'(uart_txd), 32'd1, $sformatf("stop bit %0d", i));
            repeat (cpb) @(negedge clk);
        end
        while (tx_busy) @(negedge clk);
        wait_for_frames(target);
    endtask

    // Drives a whole frame on the receive line, LSB first.
    task automatic bang_frame(input logic [7:0] value, input logic stop_level);
        int cpb;
        int db;
        cpb = int'(cfg.cycles_per_bit);
        db  = int'(cfg.data_bits);
        @(negedge clk);
        bang_rxd = 1'b0;
        repeat (cpb) @(negedge clk);
        for (int i = 0; i < db; i++) begin
            bang_rxd = value[i];
            repeat (cpb) @(negedge clk);
        end
        bang_rxd = stop_level;
        repeat (cpb) @(negedge clk);
        // Idle gap after the frame.
        bang_rxd = 1'b1;
        repeat (2 * cpb) @(negedge clk);
    endtask

    // --------------------
    // Monitors.
    // --------------------

    // Each rx_valid must match the oldest expected frame.
    always @(negedge clk) begin : rx_monitor
        uart_rx_frame_t exp_frame;
        if (resetn && rx_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_error("Receiver reported a frame that was never sent.");
            end else begin
                exp_frame = exp_q.pop_front();
                check(32'(rx_frame.data), 32'(exp_frame.data), "received data");
                check(32'(rx_frame.frame_error), 32'(exp_frame.frame_error), "frame error flag");
                rx_count++;
            end
        end
    end

    // Busy length is fixed by the frame format.
    always @(negedge clk) begin
        if (resetn && tx_busy) begin
            if (busy_len == 0) begin
                busy_expected = (1 + int'(cfg.data_bits) + int'(cfg.stop_bits))
                              * int'(cfg.cycles_per_bit);
            end
            busy_len++;
        end else if (busy_len != 0) begin
            check(32'(busy_len), 32'(busy_expected), "tx_busy length");
            busy_len = 0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_error("Timeout: the run hung while waiting for the DUT.");
    end

    // --------------------
    // Test sequence.
    // --------------------

    initial begin
        uart_rx_frame_t frame;
        int             cpb;
        int             db;
        int             sb;
        int             target;
        resetn   = 1'b0;
        tx_start = 1'b0;
        tx_data  = 8'h00;
        loopback = 1'b0;
        bang_rxd = 1'b1;
        rng      = 32'h2a6da43e;
        apply_config(8, 8, 1);
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        // Idle outputs after reset.
        check(32'(uart_txd), 32'd1, "uart_txd after reset");
        check(32'(tx_busy), 32'd0, "tx_busy after reset");
        check(32'(rx_valid), 32'd0, "rx_valid after reset");

        // Random configurations over loopback.
        loopback = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng = xorshift32(rng);
            cpb = 4 + int'(rng % 32'd17);
            rng = xorshift32(rng);
            db  = 5 + int'(rng % 32'd4);
            rng = xorshift32(rng);
            sb  = 1 + int'(rng[0]);
            apply_config(cpb, db, sb);
            rng = xorshift32(rng);
            send_and_check(rng[7:0], 1'b0);
        end

        // Strobe while busy.
        apply_config(6, 8, 2);
        send_and_check(8'ha5, 1'b1);
        // Loopback stays on for two frame lengths so a queued byte would show up.
        target = rx_count;
        repeat (2 * 11 * 6) @(negedge clk);
        check(32'(rx_count), 32'(target), "frames after dropped strobe");

        // Low stop bit from the testbench.
        loopback = 1'b0;
        apply_config(8, 6, 1);
        frame.data        = masked(8'hd6, 6);
        frame.frame_error = 1'b1;
        exp_q.push_back(frame);
        target = rx_count + 1;
        bang_frame(8'hd6, 1'b0);
        wait_for_frames(target);

        // Short low pulse, then a good frame.
        apply_config(10, 7, 2);
        target = rx_count;
        @(negedge clk);
        bang_rxd = 1'b0;
        repeat (10 / 2 - 1) @(negedge clk);
        bang_rxd = 1'b1;
        // Idle for longer than a whole frame so a taken glitch would complete.
        repeat (12 * 10) @(negedge clk);
        check(32'(rx_count), 32'(target), "frames after start glitch");
        frame.data        = masked(8'h5b, 7);
        frame.frame_error = 1'b0;
        exp_q.push_back(frame);
        bang_frame(8'h5b, 1'b1);
        wait_for_frames(target + 1);

        if (exp_q.size() != 0) begin
            stop_with_error("Some sent frames never arrived at the receiver.");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: verilog/uart_bit_timer.sv
`timescale 1ns/10ps

module uart_bit_timer
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 run,
    input  logic [CPB_WIDTH-1:0] cycles_per_bit,
    output logic                 mid_tick,
    output logic                 bit_tick
);

    // Cycle position inside the current bit period.
    logic [CPB_WIDTH-1:0] count;

    // Decoded points of the period.
    logic [CPB_WIDTH-1:0] half_point;
    logic [CPB_WIDTH-1:0] last_point;

    // --------------------
    // Period decode.
    // --------------------

    // Half period rounds down.
    assign half_point = cycles_per_bit >> 1;
    assign last_point = cycles_per_bit - CPB_WIDTH'(1);

    // Ticks only while the owner keeps the timer running.
    assign mid_tick = run && (count == half_point);
    assign bit_tick = run && (count == last_point);

    // --------------------
    // Cycle counter.
    // --------------------

    // Held at zero when stopped so the next run starts a fresh period.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (bit_tick) begin
            // Wrap into the next bit period.
            count <= '0;
        end else begin
            count <= count + CPB_WIDTH'(1);
        end
    end

endmodule

// File: verilog/uart_core.sv
`timescale 1ns/10ps

module uart_core
    import uart_pkg::*;
#(
    parameter int MAX_DATA_BITS = 8
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  uart_cfg_t                cfg,
    input  logic                     tx_start,
    input  logic [MAX_DATA_BITS-1:0] tx_data,
    output logic                     tx_busy,
    output logic                     uart_txd,
    input  logic                     uart_rxd,
    output logic                     rx_valid,
    output uart_rx_frame_t           rx_frame
);

    // Receiver result before packing.
    logic [MAX_DATA_BITS-1:0] rx_data;
    logic                     rx_frame_error;

    // --------------------
    // Transmit side.
    // --------------------

    uart_tx #(
        .MAX_DATA_BITS (MAX_DATA_BITS)
    ) i_tx (
        .clk      (clk),
        .resetn   (resetn),
        .cfg      (cfg),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .uart_txd (uart_txd)
    );

    // --------------------
    // Receive side.
    // --------------------

    uart_rx #(
        .MAX_DATA_BITS (MAX_DATA_BITS)
    ) i_rx (
        .clk            (clk),
        .resetn         (resetn),
        .cfg            (cfg),
        .uart_rxd       (uart_rxd),
        .rx_valid       (rx_valid),
        .rx_data        (rx_data),
        .rx_frame_error (rx_frame_error)
    );

    // Zero extended into the fixed 8-bit field.
    assign rx_frame.data        = 8'(rx_data);
    assign rx_frame.frame_error = rx_frame_error;

endmodule

// File: verilog/uart_pkg.sv
package uart_pkg;

    // --------------------
    // Configuration.
    // --------------------

    // Width of the cycles-per-bit field.
    localparam int CPB_WIDTH = 16;

    // Runtime line settings shared by both directions.
    // Must not change while a frame is in flight.
    typedef struct packed {
        // Clock cycles in one bit period. Minimum of 4.
        logic [CPB_WIDTH-1:0] cycles_per_bit;
        // Data bits per frame, 5 to 8.
        logic [3:0]           data_bits;
        // Stop bits per frame, 1 or 2.
        logic [1:0]           stop_bits;
    } uart_cfg_t;

    // --------------------
    // Received frame.
    // --------------------

    // Data is right aligned. Unused upper bits read as zero.
    typedef struct packed {
        logic [7:0] data;
        // Stop bit was sampled low.
        logic       frame_error;
    } uart_rx_frame_t;

    // --------------------
    // FSM states.
    // --------------------

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } uart_rx_state_t;

endpackage

// File: verilog/uart_rx.sv
`timescale 1ns/10ps

module uart_rx
    import uart_pkg::*;
#(
    parameter int MAX_DATA_BITS = 8
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  uart_cfg_t                cfg,
    input  logic                     uart_rxd,
    output logic                     rx_valid,
    output logic [MAX_DATA_BITS-1:0] rx_data,
    output logic                     rx_frame_error
);

    // Synchronizer stages and the previous synchronized level.
    logic rxd_meta;
    logic rxd_sync;
    logic rxd_prev;
    logic start_edge;

    // FSM state.
    uart_rx_state_t state;
    uart_rx_state_t state_next;

    // Samples enter at the top and move down.
    logic [MAX_DATA_BITS-1:0] shifter;
    logic [3:0]               bit_cnt;
    logic                     last_data;

    // Places to move the shifter down when fewer data bits are used.
    logic [3:0] align_shift;

    // Timer handshake.
    logic timer_run;
    logic mid_tick;

    // Completion strobe.
    logic frame_done;

    // --------------------
    // Line input.
    // --------------------

    // Idle level after reset is high so no false start is seen.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign start_edge = rxd_prev && !rxd_sync;

    // --------------------
    // Bit timer.
    // --------------------

    assign timer_run = (state != RX_IDLE);

    uart_bit_timer i_timer (
        .clk            (clk),
        .resetn         (resetn),
        .run            (timer_run),
        .cycles_per_bit (cfg.cycles_per_bit),
        .mid_tick       (mid_tick),
        .bit_tick       ()
    );

    // --------------------
    // Next state.
    // --------------------

    assign last_data  = (bit_cnt == cfg.data_bits - 4'd1);
    assign frame_done = (state == RX_STOP) && mid_tick;

    always_comb begin
        state_next = state;
        case (state)
            RX_IDLE: if (start_edge) state_next = RX_START;
            // A high line mid start bit was only a glitch.
            RX_START: if (mid_tick) state_next = rxd_sync ? RX_IDLE : RX_DATA;
            RX_DATA:  if (mid_tick && last_data) state_next = RX_STOP;
            // Only the first stop bit is checked.
            RX_STOP:  if (mid_tick) state_next = RX_IDLE;
            default:  state_next = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= RX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // --------------------
    // Datapath.
    // --------------------

    always_ff @(posedge clk) begin
        if (state == RX_DATA && mid_tick) begin
            shifter <= {rxd_sync, shifter[MAX_DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bit_cnt <= '0;
        end else if (state != RX_DATA) begin
            bit_cnt <= '0;
        end else if (mid_tick) begin
            bit_cnt <= last_data ? 4'd0 : bit_cnt + 4'd1;
        end
    end

    // Stale low bits fall off and zeros fill the top.
    assign align_shift = 4'(MAX_DATA_BITS) - cfg.data_bits;

    // Result is held until the next frame completes.
    always_ff @(posedge clk) begin
        if (frame_done) begin
            rx_data        <= shifter >> align_shift;
            rx_frame_error <= !rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= frame_done;
        end
    end

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/10ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int MAX_DATA_BITS = 8
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  uart_cfg_t                cfg,
    input  logic                     tx_start,
    input  logic [MAX_DATA_BITS-1:0] tx_data,
    output logic                     tx_busy,
    output logic                     uart_txd
);

    // FSM state.
    uart_tx_state_t state;
    uart_tx_state_t state_next;

    // Outgoing bits. Bit 0 is always the next one on the line.
    logic [MAX_DATA_BITS-1:0] shifter;

    // Counts data bits in TX_DATA and stop bits in TX_STOP.
    logic [3:0] bit_cnt;

    // Timer handshake.
    logic timer_run;
    logic bit_tick;

    // Phase decode.
    logic accept;
    logic last_data;
    logic last_stop;

    // Registered line level.
    logic txd_q;

    // --------------------
    // Bit timer.
    // --------------------

    // Runs for the whole frame.
    assign timer_run = (state != TX_IDLE);

    uart_bit_timer i_timer (
        .clk            (clk),
        .resetn         (resetn),
        .run            (timer_run),
        .cycles_per_bit (cfg.cycles_per_bit),
        .mid_tick       (),
        .bit_tick       (bit_tick)
    );

    // --------------------
    // Next state.
    // --------------------

    // Strobes while busy are dropped.
    assign accept    = tx_start && (state == TX_IDLE);
    assign last_data = (bit_cnt == cfg.data_bits - 4'd1);
    assign last_stop = (bit_cnt == {2'b00, cfg.stop_bits} - 4'd1);

    always_comb begin
        state_next = state;
        case (state)
            TX_IDLE:  if (accept) state_next = TX_START;
            TX_START: if (bit_tick) state_next = TX_DATA;
            TX_DATA:  if (bit_tick && last_data) state_next = TX_STOP;
            TX_STOP:  if (bit_tick && last_stop) state_next = TX_IDLE;
            default:  state_next = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= TX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Busy from the cycle after acceptance until the frame ends.
    assign tx_busy = (state != TX_IDLE);

    // --------------------
    // Datapath.
    // --------------------

    // Loaded on acceptance. Shifted right at the end of each data bit.
    always_ff @(posedge clk) begin
        if (accept) begin
            shifter <= tx_data;
        end else if (state == TX_DATA && bit_tick) begin
            shifter <= {1'b0, shifter[MAX_DATA_BITS-1:1]};
        end
    end

    // Restarts at each phase change.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            bit_cnt <= '0;
        end else if (state == TX_IDLE) begin
            bit_cnt <= '0;
        end else if (bit_tick) begin
            if (state == TX_START || (state == TX_DATA && last_data)) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // Line output lags the state by one cycle.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            txd_q <= 1'b1;
        end else begin
            case (state)
                TX_START: txd_q <= 1'b0;
                TX_DATA:  txd_q <= shifter[0];
                default:  txd_q <= 1'b1;
            endcase
        end
    end

    assign uart_txd = txd_q;

endmodule
